// File: hw/uart_pkg.sv
package uart_pkg;

   // ticks per bit period; tick counters in tx and rx are sized from this
   localparam int OVERSAMPLE = 16;

   // transmitter states
   typedef enum logic [1:0] {
      TX_IDLE = 2'b00,   // line high, waiting for a start strobe
      TX_SEND = 2'b01,   // shifting start, data and stop bits
      TX_STOP = 2'b10    // holding the stop bit for one bit period
   } tx_state_t;

   // receiver states
   typedef enum logic [1:0] {
      RX_IDLE  = 2'b00,  // waiting for a falling edge
      RX_START = 2'b01,  // checking the start bit at its middle
      RX_DATA  = 2'b10,  // sampling data bits lsb first
      RX_STOP  = 2'b11   // sampling the stop bit
   } rx_state_t;

   // receive status, both bits valid for a single cycle
   typedef struct packed {
      logic valid;       // word complete
      logic frame_err;   // stop bit sampled low
   } rx_flags_t;

endpackage

// File: hw/uart_tick_gen.sv
`timescale 1ns/1ns

// Oversampling strobe source. The counter runs down from CLKS_PER_TICK-1
// and reloads when it hits zero, so o_tick is high one cycle in every
// CLKS_PER_TICK cycles.
module uart_tick_gen #(
   parameter int CLKS_PER_TICK = 4
) (
   input  logic i_clk,
   input  logic i_rst,
   output logic o_tick
);

   localparam int CW = (CLKS_PER_TICK > 2) ? $clog2(CLKS_PER_TICK) : 1;
   localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_TICK - 1);

   logic [CW-1:0] count;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         count  <= RELOAD;
         o_tick <= 1'b0;
      end else begin
         if (count == '0) begin
            count  <= RELOAD;          // wrap
            o_tick <= 1'b1;
         end else begin
            count  <= count - 1'b1;
            o_tick <= 1'b0;
         end
      end
   end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

// Transmit shifter. A request in idle loads {stop, data, start} and clears
// the tick counter. Each time the counter overflows into its top bit one
// bit goes out on the line, lsb first. After DATA_BITS+2 shifts done
// pulses and the stop bit is held for one more bit period.
module uart_tx import uart_pkg::*; #(
   parameter int DATA_BITS = 8
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_rate,
   input  logic                 i_data_ready,
   input  logic [DATA_BITS-1:0] i_data,
   output logic                 o_tx,
   output logic                 o_tx_done,
   output logic                 o_tx_busy
);

   localparam int TW = $clog2(OVERSAMPLE) + 1;      // one extra bit as overflow flag
   localparam int BW = $clog2(DATA_BITS + 3);
   localparam logic [BW-1:0] LAST_BIT = BW'(DATA_BITS + 2);

   tx_state_t            state;
   logic [TW-1:0]        time_count;
   logic [TW-1:0]        time_next;
   logic [BW-1:0]        bit_count;
   logic [DATA_BITS+1:0] shift_reg;                 // stop + data + start
   logic                 load;
   logic                 shift_en;
   logic                 frame_end;

   assign time_next = time_count + TW'(i_rate);
   assign load      = (state == TX_IDLE) && i_data_ready;  // dropped while busy
   assign frame_end = (state == TX_SEND) && (bit_count == LAST_BIT);
   assign shift_en  = (state == TX_SEND) && !frame_end && time_count[TW-1];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state      <= TX_IDLE;
         time_count <= '0;
         bit_count  <= '0;
         o_tx       <= 1'b1;   // idle line
         o_tx_done  <= 1'b0;
      end else begin
         o_tx_done  <= 1'b0;
         time_count <= time_next;
         case (state)
            TX_IDLE: begin
               if (load) begin
                  state      <= TX_SEND;
                  bit_count  <= '0;
                  time_count <= '0;
               end
            end
            TX_SEND: begin
               if (frame_end) begin
                  o_tx_done  <= 1'b1;
                  time_count <= '0;
                  state      <= TX_STOP;
               end else if (shift_en) begin
                  o_tx       <= shift_reg[0];
                  bit_count  <= bit_count + 1'b1;
                  time_count <= {1'b0, time_next[TW-2:0]};  // drop overflow, keep phase
               end
            end
            TX_STOP: begin
               if (time_count[TW-1]) begin
                  state <= TX_IDLE;   // stop bit held a full period
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   // payload, only meaningful between load and the last shift
   always_ff @(posedge i_clk) begin
      if (load) begin
         shift_reg <= {1'b1, i_data, 1'b0};
      end else if (shift_en) begin
         shift_reg <= {1'b1, shift_reg[DATA_BITS+1:1]};  // back-fill with idle level
      end
   end

   assign o_tx_busy = (state != TX_IDLE);

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/1ns

// Receiver. The line is synchronized, a falling edge in idle starts a
// half-bit count, and the start bit is confirmed at its middle. From there
// every OVERSAMPLE ticks lands in the middle of the next bit. The stop bit
// sample completes the word and sets the flags.
module uart_rx import uart_pkg::*; #(
   parameter int DATA_BITS = 8
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_rate,
   input  logic                 i_rx,
   output logic [DATA_BITS-1:0] o_rx_data,
   output rx_flags_t            o_rx_flags
);

   localparam int TW = $clog2(OVERSAMPLE);
   localparam int BW = (DATA_BITS > 2) ? $clog2(DATA_BITS) : 1;
   localparam logic [TW-1:0] MID_TICK  = TW'(OVERSAMPLE / 2 - 1);
   localparam logic [TW-1:0] LAST_TICK = TW'(OVERSAMPLE - 1);
   localparam logic [BW-1:0] LAST_BIT  = BW'(DATA_BITS - 1);

   rx_state_t            state;
   logic                 rx_meta;
   logic                 rx_sync;
   logic                 rx_prev;
   logic [TW-1:0]        tick_count;
   logic [BW-1:0]        bit_count;
   logic [DATA_BITS-1:0] shift_reg;
   logic                 fall;
   logic                 mid_bit;
   logic                 bit_done;
   logic                 stop_sample;

   assign fall        = rx_prev && !rx_sync;
   assign mid_bit     = i_rate && (tick_count == MID_TICK);
   assign bit_done    = i_rate && (tick_count == LAST_TICK);
   assign stop_sample = (state == RX_STOP) && bit_done;

   // two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state      <= RX_IDLE;
         tick_count <= '0;
         bit_count  <= '0;
         o_rx_flags <= '0;
      end else begin
         o_rx_flags <= '0;
         if (i_rate) begin
            tick_count <= tick_count + 1'b1;
         end
         case (state)
            RX_IDLE: begin
               if (fall) begin
                  state      <= RX_START;
                  tick_count <= '0;
               end
            end
            RX_START: begin
               if (mid_bit) begin
                  tick_count <= '0;
                  bit_count  <= '0;
                  state      <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back quietly
               end
            end
            RX_DATA: begin
               if (bit_done) begin
                  tick_count <= '0;
                  bit_count  <= bit_count + 1'b1;
                  if (bit_count == LAST_BIT) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (stop_sample) begin
                  o_rx_flags.valid     <= 1'b1;
                  o_rx_flags.frame_err <= !rx_sync;
                  state                <= RX_IDLE;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // data path, lsb arrives first so shift in from the top
   always_ff @(posedge i_clk) begin
      if ((state == RX_DATA) && bit_done) begin
         shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
      end
      if (stop_sample) begin
         o_rx_data <= shift_reg;   // held until the next word
      end
   end

endmodule

// File: hw/uart_core.sv
`timescale 1ns/1ns

// UART core: one tick generator shared by the transmitter and receiver
module uart_core import uart_pkg::*; #(
   parameter int DATA_BITS     = 8,
   parameter int CLKS_PER_TICK = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   // transmit side
   input  logic                 i_tx_start,
   input  logic [DATA_BITS-1:0] i_tx_data,
   output logic                 o_tx,
   output logic                 o_tx_done,
   output logic                 o_tx_busy,
   // receive side
   input  logic                 i_rx,
   output logic [DATA_BITS-1:0] o_rx_data,
   output rx_flags_t            o_rx_flags
);

   logic tick;   // OVERSAMPLE x bit rate

   uart_tick_gen #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) u_tick (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .o_tick (tick)
   );

   uart_tx #(
      .DATA_BITS (DATA_BITS)
   ) u_tx (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_rate       (tick),
      .i_data_ready (i_tx_start),
      .i_data       (i_tx_data),
      .o_tx         (o_tx),
      .o_tx_done    (o_tx_done),
      .o_tx_busy    (o_tx_busy)
   );

   uart_rx #(
      .DATA_BITS (DATA_BITS)
   ) u_rx (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rate     (tick),
      .i_rx       (i_rx),
      .o_rx_data  (o_rx_data),
      .o_rx_flags (o_rx_flags)
   );

endmodule

// File: verification/uart_properties.sv
`timescale 1ns/1ns

module uart_properties import uart_pkg::*; (
   input logic      i_clk,
   input logic      i_rst,
   input tx_state_t i_state,
   input logic      i_tx,
   input logic      i_tx_done
);

   int assert_fails = 0;

   idle_line_high: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_state == TX_IDLE) |-> i_tx)
      else begin assert_fails++; $error("o_tx low while TX_IDLE"); end

   done_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_tx_done |=> !i_tx_done)
      else begin assert_fails++; $error("o_tx_done longer than one cycle"); end

   done_on_stop_entry: assert property (@(posedge i_clk) disable iff (i_rst)
      i_tx_done |-> (i_state == TX_STOP) && ($past(i_state) == TX_SEND))
      else begin assert_fails++; $error("o_tx_done outside TX_STOP entry"); end

endmodule

bind uart_tx uart_properties u_props (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_state   (state),
   .i_tx      (o_tx),
   .i_tx_done (o_tx_done)
);

// File: verification/uart_checker.sv
`timescale 1ns/1ns

module uart_checker import uart_pkg::*; #(
   parameter int DATA_BITS  = 8,
   parameter int BIT_CYCLES = 64
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_tx_start,
   input  logic [DATA_BITS-1:0] i_tx_data,
   input  logic                 i_tx,
   input  logic                 i_tx_done,
   input  logic                 i_tx_busy,
   input  logic [DATA_BITS-1:0] i_rx_data,
   input  rx_flags_t            i_rx_flags,
   input  logic                 i_loopback,
   input  logic                 i_inj_push,
   input  logic [DATA_BITS-1:0] i_inj_data,
   input  logic                 i_inj_ferr,
   input  int                   i_test_num,
   input  logic                 i_test_done,
   output int                   o_errors,
   output int                   o_passed,
   output int                   o_failed
);

   logic [DATA_BITS-1:0] tx_exp[$];
   logic [DATA_BITS:0]   rx_exp[$];   // {frame_err, data}
   int                   done_seen = 0;
   int                   test_base = 0;

   initial begin
      o_errors = 0;
      o_passed = 0;
      o_failed = 0;
   end

   function automatic string test_name(input int n);
      case (n)
         1:       return "reset idle";
         2:       return "line format";
         3:       return "loopback";
         4:       return "start while busy";
         5:       return "frame error and false start";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
      $display("Fail %s exp %h got %h", sig, exp, got);
      o_errors++;
   endtask

   task automatic report_text(input string msg);
      $display("%s", msg);
      o_errors++;
   endtask

   // expected words, acceptance only when not busy
   always @(posedge i_clk) begin
      if (!i_rst) begin
         if (i_tx_start && !i_tx_busy) begin
            tx_exp.push_back(i_tx_data);
            if (i_loopback) rx_exp.push_back({1'b0, i_tx_data});
         end
         if (i_inj_push) rx_exp.push_back({i_inj_ferr, i_inj_data});
         if (i_tx_done) done_seen++;
         if (i_rx_flags.valid) begin
            if (rx_exp.size() == 0) begin
               report_text("valid pulse with no word expected");
            end else begin
               if (i_rx_data !== rx_exp[0][DATA_BITS-1:0])
                  report_value("o_rx_data", 32'(rx_exp[0][DATA_BITS-1:0]), 32'(i_rx_data));
               if (i_rx_flags.frame_err !== rx_exp[0][DATA_BITS])
                  report_value("frame_err", 32'(rx_exp[0][DATA_BITS]),
                               32'(i_rx_flags.frame_err));
               void'(rx_exp.pop_front());
            end
         end
         if (i_test_num == 1) begin   // everything quiet
            if (i_tx !== 1'b1) report_value("o_tx", 32'd1, 32'(i_tx));
            if (i_tx_busy !== 1'b0) report_value("o_tx_busy", 32'd0, 32'(i_tx_busy));
            if (i_tx_done !== 1'b0) report_value("o_tx_done", 32'd0, 32'(i_tx_done));
            if (i_rx_flags !== 2'b00) report_value("o_rx_flags", 32'd0, 32'(i_rx_flags));
         end
         if (i_test_done) begin
            if (tx_exp.size() != 0) report_text("accepted word never appeared on o_tx");
            if (rx_exp.size() != 0) report_text("expected word got no valid pulse");
            tx_exp.delete();
            rx_exp.delete();
            if (o_errors == test_base) o_passed++;
            else o_failed++;
            $display("test %0d %s: %s, %0d errors", i_test_num, test_name(i_test_num),
                     (o_errors == test_base) ? "pass" : "fail", o_errors - test_base);
            test_base = o_errors;
         end
      end
   end

   // independent o_tx decoder, samples at bit centers
   initial begin
      logic [DATA_BITS-1:0] word;
      logic                 start_bit;
      logic                 stop_bit;
      logic                 busy_start;
      logic                 busy_stop;
      forever begin
         @(negedge i_tx);
         if (!i_rst) begin
            done_seen = 0;
            repeat (BIT_CYCLES / 2) @(posedge i_clk);
            start_bit  = i_tx;
            busy_start = i_tx_busy;   // frame in flight
            for (int i = 0; i < DATA_BITS; i++) begin
               repeat (BIT_CYCLES) @(posedge i_clk);
               word[i] = i_tx;
            end
            repeat (BIT_CYCLES) @(posedge i_clk);
            stop_bit  = i_tx;
            busy_stop = i_tx_busy;    // still holding the stop bit
            if (start_bit !== 1'b0) report_value("o_tx start bit", 32'd0, 32'(start_bit));
            if (stop_bit !== 1'b1) report_value("o_tx stop bit", 32'd1, 32'(stop_bit));
            if (busy_start !== 1'b1) report_value("o_tx_busy", 32'd1, 32'(busy_start));
            if (busy_stop !== 1'b1) report_value("o_tx_busy", 32'd1, 32'(busy_stop));
            if (tx_exp.size() == 0) begin
               report_text("frame on o_tx with no accepted word");
            end else begin
               if (word !== tx_exp[0]) report_value("o_tx data", 32'(tx_exp[0]), 32'(word));
               void'(tx_exp.pop_front());
            end
            if (done_seen == 0) report_text("no done pulse after frame");
            else if (done_seen > 1) report_text("more than one done pulse for a frame");
         end
      end
   end

endmodule

// File: verification/uart_tb.sv
`timescale 1ns/1ns

module uart_tb import uart_pkg::*; ();

   localparam int DATA_BITS     = 8;
   localparam int CLKS_PER_TICK = 4;
   localparam int BIT_CYCLES    = OVERSAMPLE * CLKS_PER_TICK;
   localparam int MAX_CYCLES    = 45 * 12 * BIT_CYCLES + 2000;

   logic                 clk;
   logic                 rst;
   logic                 tx_start;
   logic [DATA_BITS-1:0] tx_data;
   logic                 tx_line;
   logic                 tx_done;
   logic                 tx_busy;
   logic                 rx_line;
   logic [DATA_BITS-1:0] rx_data;
   rx_flags_t            rx_flags;
   logic                 loopback;
   logic                 inj_line;
   logic                 inj_push;
   logic [DATA_BITS-1:0] inj_data;
   logic                 inj_ferr;
   logic                 test_done;
   int                   test_num;
   int                   errors;
   int                   passed;
   int                   failed;
   int                   cycles = 0;
   logic [31:0]          seed;

   assign rx_line = loopback ? tx_line : inj_line;   // loopback or bit-banged frames

   uart_core #(
      .DATA_BITS     (DATA_BITS),
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) u_dut (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_tx_start (tx_start),
      .i_tx_data  (tx_data),
      .o_tx       (tx_line),
      .o_tx_done  (tx_done),
      .o_tx_busy  (tx_busy),
      .i_rx       (rx_line),
      .o_rx_data  (rx_data),
      .o_rx_flags (rx_flags)
   );

   uart_checker #(
      .DATA_BITS  (DATA_BITS),
      .BIT_CYCLES (BIT_CYCLES)
   ) u_chk (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_tx_start  (tx_start),
      .i_tx_data   (tx_data),
      .i_tx        (tx_line),
      .i_tx_done   (tx_done),
      .i_tx_busy   (tx_busy),
      .i_rx_data   (rx_data),
      .i_rx_flags  (rx_flags),
      .i_loopback  (loopback),
      .i_inj_push  (inj_push),
      .i_inj_data  (inj_data),
      .i_inj_ferr  (inj_ferr),
      .i_test_num  (test_num),
      .i_test_done (test_done),
      .o_errors    (errors),
      .o_passed    (passed),
      .o_failed    (failed)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic get_random(output logic [DATA_BITS-1:0] v);
      seed = lcg_next(seed);
      v    = seed[23:16];   // upper bits have the longer period
   endtask

   task automatic send_word(input logic [DATA_BITS-1:0] w);
      @(negedge clk);
      while (tx_busy) @(negedge clk);
      tx_start = 1'b1;
      tx_data  = w;
      @(negedge clk);
      tx_start = 1'b0;
   endtask

   task automatic wait_frame_end();
      while (!tx_done) @(negedge clk);
      while (tx_busy) @(negedge clk);
   endtask

   task automatic end_test();
      repeat (BIT_CYCLES) @(negedge clk);   // let the last rx word land
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
      @(negedge clk);
   endtask

   task automatic inject_frame(input logic [DATA_BITS-1:0] w, input logic stop);
      inj_data = w;
      inj_ferr = !stop;
      inj_push = 1'b1;
      @(negedge clk);
      inj_push = 1'b0;
      inj_line = 1'b0;                      // start bit
      repeat (BIT_CYCLES) @(negedge clk);
      for (int i = 0; i < DATA_BITS; i++) begin
         inj_line = w[i];
         repeat (BIT_CYCLES) @(negedge clk);
      end
      inj_line = stop;
      repeat (BIT_CYCLES) @(negedge clk);
      inj_line = 1'b1;
      repeat (BIT_CYCLES) @(negedge clk);   // idle gap
   endtask

   task automatic inject_glitch();
      inj_line = 1'b0;
      repeat (5 * CLKS_PER_TICK) @(negedge clk);   // 5 ticks, well short of mid-bit
      inj_line = 1'b1;
      repeat (2 * BIT_CYCLES) @(negedge clk);
   endtask

   initial begin
      logic [DATA_BITS-1:0] w;
      logic [DATA_BITS-1:0] x;
      rst       = 1'b1;
      tx_start  = 1'b0;
      tx_data   = '0;
      loopback  = 1'b0;
      inj_line  = 1'b1;
      inj_push  = 1'b0;
      inj_data  = '0;
      inj_ferr  = 1'b0;
      test_done = 1'b0;
      test_num  = 0;
      seed      = 32'he6a2;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_num = 1;   // idle after reset
      repeat (200) @(negedge clk);
      end_test();

      test_num = 2;   // line format, rx side held idle
      for (int n = 0; n < 20; n++) begin
         get_random(w);
         send_word(w);
         wait_frame_end();
      end
      end_test();

      test_num = 3;
      loopback = 1'b1;
      for (int n = 0; n < 10; n++) begin
         get_random(w);
         send_word(w);
         wait_frame_end();
      end
      end_test();

      test_num = 4;   // strobes while busy must be dropped
      for (int n = 0; n < 5; n++) begin
         get_random(w);
         send_word(w);
         for (int k = 0; k < 3; k++) begin
            repeat (40) @(negedge clk);
            if (tx_busy) begin
               get_random(x);
               if (x == w) x = ~w;
               tx_start = 1'b1;
               tx_data  = x;
               @(negedge clk);
               tx_start = 1'b0;
            end
         end
         wait_frame_end();
      end
      end_test();

      test_num = 5;
      loopback = 1'b0;
      for (int n = 0; n < 3; n++) begin
         get_random(w);
         inject_frame(w, 1'b0);
      end
      inject_glitch();
      for (int n = 0; n < 3; n++) begin
         get_random(w);
         inject_frame(w, 1'b1);
      end
      end_test();

      $display("summary: %0d tests passed, %0d tests failed, %0d errors, %0d assertion failures",
               passed, failed, errors, u_dut.u_tx.u_props.assert_fails);
      if (failed == 0 && errors == 0 && u_dut.u_tx.u_props.assert_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: project.f
hw/uart_pkg.sv
hw/uart_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
verification/uart_properties.sv
verification/uart_checker.sv
verification/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module uart_tb -o uart_sim

./obj_dir/uart_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
